// File: tb.f
+incdir+source
source/ad_pkg.sv
source/fx_bus_if.sv
source/fx_bus_port.sv
source/ad_reg.sv
source/ad_sample_gen.sv
source/ad_sample_merge.sv
source/ad_capture_top.sv
sim/tb_ad_capture.sv

// File: sim/tb_ad_capture.sv
// table-driven testbench for the acquisition front end

`include "ad_defines.svh"

module tb_ad_capture;

	timeunit 1ns;
	timeprecision 1ps;

	import ad_pkg::*;

	localparam int STEP_LIMIT = 500;

	typedef enum {K_WR, K_RD, K_NZ, K_SYNC, K_SMP, K_HOLD, K_RR} kind_e;

	typedef struct {
		kind_e      kind;
		int         ch;
		logic [7:0] off;
		ad_sample_t value;
		ad_sample_t exp_val;
	} step_t;

	typedef struct {
		logic [1:0] ch;
		ad_sample_t data;
	} rec_t;

	logic        clk_sys;
	logic        rst_n;
	logic        fx_wr;
	logic [15:0] fx_waddr;
	logic [7:0]  fx_data;
	logic        fx_rd;
	logic [15:0] fx_raddr;
	logic [7:0]  fx_q;
	ad_sample_t  adc_data [`AD_NUM_CH];
	logic        out_valid;
	logic        out_ready;
	ad_sample_t  out_data;
	logic [1:0]  out_ch;

	step_t      tab[$];
	rec_t       smp_q[$];
	logic [1:0] tag_q[$];
	bit         tab_ready;
	int         n_pass;
	int         n_fail;

	ad_capture_top dut0 (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.fx_wr     (fx_wr),
		.fx_waddr  (fx_waddr),
		.fx_data   (fx_data),
		.fx_rd     (fx_rd),
		.fx_raddr  (fx_raddr),
		.fx_q      (fx_q),
		.adc_data  (adc_data),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_data  (out_data),
		.out_ch    (out_ch)
	);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	// ----------------------------------------
	// stream monitor
	// ----------------------------------------
	always @(posedge clk_sys) begin
		rec_t r;
		if (rst_n && out_valid && out_ready) begin
			r.ch = out_ch;
			r.data = out_data;
			smp_q.push_back(r);
			tag_q.push_back(out_ch);
		end
	end

	// ----------------------------------------
	// compare tasks
	// ----------------------------------------
	task automatic check_byte(string name, logic [7:0] got, logic [7:0] exp_val);
		if (got === exp_val) begin
			n_pass++;
			$display("[PASS] %s = %h", name, got);
		end else begin
			n_fail++;
			$display("[FAIL] %s got %h expected %h", name, got, exp_val);
		end
	endtask

	task automatic check_sample(string name, ad_sample_t got, ad_sample_t exp_val);
		if (got === exp_val) begin
			n_pass++;
			$display("[PASS] %s = %h", name, got);
		end else begin
			n_fail++;
			$display("[FAIL] %s got %h expected %h", name, got, exp_val);
		end
	endtask

	task automatic check_ch(string name, logic [1:0] got, logic [1:0] exp_val);
		if (got === exp_val) begin
			n_pass++;
			$display("[PASS] %s = %h", name, got);
		end else begin
			n_fail++;
			$display("[FAIL] %s got %h expected %h", name, got, exp_val);
		end
	endtask

	task automatic report_error(string msg);
		n_fail++;
		$display("[ERROR] %s", msg);
	endtask

	// ----------------------------------------
	// fx bus access
	// ----------------------------------------
	function automatic logic [15:0] reg_addr(int ch, logic [7:0] off);
		return {2'b00, 6'(`AD_MOD_ID_BASE + ch), off};
	endfunction

	task automatic bus_write(logic [15:0] addr, logic [7:0] data);
		@(posedge clk_sys);
		fx_wr    <= 1'b1;
		fx_waddr <= addr;
		fx_data  <= data;
		@(posedge clk_sys);
		fx_wr    <= 1'b0;
	endtask

	// fx_q holds the value for one cycle, 3 edges after the strobe is taken
	task automatic bus_read(logic [15:0] addr, output logic [7:0] data);
		@(posedge clk_sys);
		fx_rd    <= 1'b1;
		fx_raddr <= addr;
		@(posedge clk_sys);
		fx_rd    <= 1'b0;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		data = fx_q;
	endtask

	// ----------------------------------------
	// stream helpers
	// ----------------------------------------

	// oldest unchecked sample of one channel
	task automatic pop_sample(int ch, output ad_sample_t data, output bit found);
		int waited;
		int idx;
		found = 1'b0;
		waited = 0;
		while (!found && waited < STEP_LIMIT) begin
			idx = -1;
			for (int i = 0; i < smp_q.size(); i++) begin
				if (idx < 0 && smp_q[i].ch == 2'(ch)) idx = i;
			end
			if (idx >= 0) begin
				data = smp_q[idx].data;
				smp_q.delete(idx);
				found = 1'b1;
			end else begin
				@(posedge clk_sys);
				waited++;
			end
		end
	endtask

	// skip stale samples of the channel up to the first expected one
	task automatic sync_sample(int ch, ad_sample_t exp_val);
		int waited;
		int idx;
		waited = 0;
		idx = -1;
		while (idx < 0 && waited < STEP_LIMIT) begin
			for (int i = 0; i < smp_q.size(); i++) begin
				if (idx < 0 && smp_q[i].data == exp_val) idx = i;
			end
			if (idx < 0) begin
				@(posedge clk_sys);
				waited++;
			end
		end
		if (idx < 0) begin
			report_error($sformatf("channel %0d never produced sample %h", ch, exp_val));
		end else begin
			check_ch($sformatf("out_ch of sample %h", exp_val), smp_q[idx].ch, 2'(ch));
			for (int i = idx; i >= 0; i--) begin
				if (i == idx || smp_q[i].ch == 2'(ch)) smp_q.delete(i);
			end
		end
	endtask

	task automatic hold_output(int cycles);
		@(posedge clk_sys);
		out_ready <= 1'b0;
		repeat (cycles) @(posedge clk_sys);
		tag_q.delete();
		out_ready <= 1'b1;
	endtask

	// every channel waits after a hold, so tags must step by one
	task automatic check_round_robin(int n);
		int waited;
		waited = 0;
		while (tag_q.size() <= n && waited < STEP_LIMIT) begin
			@(posedge clk_sys);
			waited++;
		end
		if (tag_q.size() <= n) begin
			report_error("too few samples after back-pressure to check the round-robin order");
		end else begin
			for (int i = 1; i <= n; i++) begin
				check_ch($sformatf("out_ch[%0d]", i), tag_q[i], 2'(tag_q[i-1] + 2'd1));
			end
		end
	endtask

	// ----------------------------------------
	// stimulus table
	// ----------------------------------------
	function automatic void add_step(kind_e kind, int ch, logic [7:0] off,
			ad_sample_t value, ad_sample_t exp_val);
		step_t s;
		s.kind = kind;
		s.ch = ch;
		s.off = off;
		s.value = value;
		s.exp_val = exp_val;
		tab.push_back(s);
	endfunction

	function automatic logic [7:0] reset_value(logic [7:0] off);
		if (off == `AD_REG_SAMPLE) return 8'h14;
		if (off == `AD_REG_STEP) return 8'h01;
		if (off >= `AD_REG_DBG0 && off <= `AD_REG_DBG0 + 8'd7) return off;
		return 8'h00;
	endfunction

	function automatic ad_sample_t adc_value(int ch);
		return 24'hC0_0000 + 24'(ch * 17);
	endfunction

	task automatic build_table();
		logic [7:0] offs [17];
		logic [7:0] wval [17];
		ad_sample_t fix_val;
		ad_sample_t base1;
		ad_sample_t base3;
		logic [7:0] step1;
		logic [7:0] step3;
		offs[0] = `AD_REG_SAMPLE;
		offs[1] = `AD_REG_TP;
		for (int i = 0; i < 3; i++) begin
			offs[2+i] = `AD_REG_FIX0 + 8'(i);
			offs[5+i] = `AD_REG_BASE0 + 8'(i);
		end
		offs[8] = `AD_REG_STEP;
		for (int i = 0; i < 8; i++) offs[9+i] = `AD_REG_DBG0 + 8'(i);

		// reset values on every channel
		for (int c = 0; c < `AD_NUM_CH; c++) begin
			add_step(K_RD, c, `AD_REG_ID, 0, 24'(`AD_MOD_ID_BASE + c));
			add_step(K_RD, c, `AD_REG_SAMPLE, 0, reset_value(`AD_REG_SAMPLE));
			add_step(K_RD, c, `AD_REG_STEP, 0, reset_value(`AD_REG_STEP));
			for (int i = 0; i < 8; i++) begin
				add_step(K_RD, c, offs[9+i], 0, reset_value(offs[9+i]));
			end
			add_step(K_RD, c, 8'h30, 0, 0);
		end

		// random bytes on channel 3, channel 2 untouched, empty module ids
		for (int i = 0; i < 17; i++) begin
			wval[i] = 8'($urandom);
			// a byte equal to the reset value would hide a lost write
			if (wval[i] == reset_value(offs[i])) wval[i] = ~wval[i];
			add_step(K_WR, 3, offs[i], wval[i], 0);
		end
		for (int i = 0; i < 17; i++) add_step(K_RD, 3, offs[i], 0, wval[i]);
		for (int i = 0; i < 17; i++) add_step(K_RD, 2, offs[i], 0, reset_value(offs[i]));
		add_step(K_RD, 8, `AD_REG_ID, 0, 0);
		add_step(K_RD, 12, `AD_REG_SAMPLE, 0, 0);
		add_step(K_WR, 3, `AD_REG_TP, 0, 0);
		add_step(K_WR, 3, `AD_REG_SAMPLE, 20, 0);

		// channel 0 fix mode, divider 4
		fix_val = 24'($urandom);
		for (int i = 0; i < 3; i++) add_step(K_WR, 0, offs[2+i], fix_val[8*i +: 8], 0);
		add_step(K_WR, 0, `AD_REG_SAMPLE, 4, 0);
		add_step(K_WR, 0, `AD_REG_TP, AD_MODE_FIX, 0);
		add_step(K_SYNC, 0, 0, 0, fix_val);
		for (int i = 0; i < 3; i++) add_step(K_SMP, 0, 0, 0, fix_val);

		// channel 2 stays in adc mode
		add_step(K_SYNC, 2, 0, 0, adc_value(2));
		for (int i = 0; i < 2; i++) add_step(K_SMP, 2, 0, 0, adc_value(2));

		// channel 1 ramp, then a hold and the round-robin order
		base1 = 24'($urandom);
		step1 = 8'($urandom) | 8'h01;
		for (int i = 0; i < 3; i++) add_step(K_WR, 1, offs[5+i], base1[8*i +: 8], 0);
		add_step(K_WR, 1, `AD_REG_STEP, step1, 0);
		add_step(K_WR, 1, `AD_REG_SAMPLE, 3, 0);
		add_step(K_WR, 1, `AD_REG_TP, AD_MODE_RAMP, 0);
		add_step(K_SYNC, 1, 0, 0, base1);
		for (int i = 1; i <= 3; i++) add_step(K_SMP, 1, 0, 0, 24'(base1 + i * step1));
		add_step(K_HOLD, 1, 0, 100, 0);
		add_step(K_RR, 0, 0, 4, 0);
		for (int i = 4; i <= 6; i++) add_step(K_SMP, 1, 0, 0, 24'(base1 + i * step1));

		// two ramps at divider 1 under long back-pressure
		base3 = 24'($urandom);
		step3 = 8'($urandom) | 8'h01;
		for (int i = 0; i < 3; i++) add_step(K_WR, 3, offs[5+i], base3[8*i +: 8], 0);
		add_step(K_WR, 3, `AD_REG_STEP, step3, 0);
		add_step(K_WR, 3, `AD_REG_SAMPLE, 1, 0);
		add_step(K_WR, 3, `AD_REG_TP, AD_MODE_RAMP, 0);
		add_step(K_WR, 1, `AD_REG_SAMPLE, 1, 0);
		add_step(K_SYNC, 3, 0, 0, base3);
		add_step(K_HOLD, 3, 0, 200, 0);
		add_step(K_NZ, 1, `AD_REG_DROP, 0, 0);
		add_step(K_NZ, 3, `AD_REG_DROP, 0, 0);
		for (int i = 7; i <= 10; i++) add_step(K_SMP, 1, 0, 0, 24'(base1 + i * step1));
		for (int i = 1; i <= 4; i++) add_step(K_SMP, 3, 0, 0, 24'(base3 + i * step3));
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial begin
		step_t      s;
		logic [7:0] rd;
		ad_sample_t smp;
		bit         found;
		void'($urandom(11397));
		rst_n = 1'b0;
		fx_wr = 1'b0;
		fx_waddr = '0;
		fx_data = '0;
		fx_rd = 1'b0;
		fx_raddr = '0;
		out_ready = 1'b1;
		for (int c = 0; c < `AD_NUM_CH; c++) adc_data[c] = adc_value(c);
		n_pass = 0;
		n_fail = 0;
		build_table();
		tab_ready = 1'b1;
		repeat (8) @(posedge clk_sys);
		rst_n <= 1'b1;

		foreach (tab[t]) begin
			s = tab[t];
			case (s.kind)
				K_WR: bus_write(reg_addr(s.ch, s.off), s.value[7:0]);
				K_RD: begin
					bus_read(reg_addr(s.ch, s.off), rd);
					check_byte($sformatf("fx_q id %h off %h", 6'(`AD_MOD_ID_BASE + s.ch), s.off),
						rd, s.exp_val[7:0]);
				end
				K_NZ: begin
					bus_read(reg_addr(s.ch, s.off), rd);
					if (rd == 8'h00) begin
						report_error($sformatf("channel %0d drop counter still zero", s.ch));
					end else begin
						n_pass++;
						$display("[PASS] drop_cnt ch%0d = %h", s.ch, rd);
					end
				end
				K_SYNC: sync_sample(s.ch, s.exp_val);
				K_SMP: begin
					pop_sample(s.ch, smp, found);
					if (!found) begin
						report_error($sformatf("channel %0d sample missing", s.ch));
					end else begin
						check_sample($sformatf("out_data ch%0d", s.ch), smp, s.exp_val);
					end
				end
				K_HOLD: hold_output(int'(s.value));
				K_RR: check_round_robin(int'(s.value));
			endcase
		end

		repeat (4) @(posedge clk_sys);
		$display("checks passed %0d failed %0d", n_pass, n_fail);
		if (n_fail == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	// watchdog sized from the table length
	initial begin
		wait (tab_ready);
		repeat (tab.size() * 400) @(posedge clk_sys);
		$display("timeout, the table did not finish within %0d cycles", tab.size() * 400);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// File: source/ad_capture_top.sv
// acquisition front end top: fx bus port, per-channel registers and generators, merger

`include "ad_defines.svh"

module ad_capture_top (
	input  logic               clk_sys,
	input  logic               rst_n,
	input  logic               fx_wr,
	input  logic [15:0]        fx_waddr,
	input  logic [7:0]         fx_data,
	input  logic               fx_rd,
	input  logic [15:0]        fx_raddr,
	output logic [7:0]         fx_q,
	input  ad_pkg::ad_sample_t adc_data [`AD_NUM_CH],
	output logic               out_valid,
	input  logic               out_ready,
	output ad_pkg::ad_sample_t out_data,
	output logic [1:0]         out_ch
);

	import ad_pkg::*;

	logic [7:0]            ch_rdata [`AD_NUM_CH];
	logic [`AD_NUM_CH-1:0] smp_valid;
	logic [`AD_NUM_CH-1:0] smp_ready;
	ad_sample_t            smp_data [`AD_NUM_CH];

	fx_bus_if fx_bus0 ();

	// ----------------------------------------
	// fx bus port
	// ----------------------------------------
	fx_bus_port port0 (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.fx_wr    (fx_wr),
		.fx_waddr (fx_waddr),
		.fx_data  (fx_data),
		.fx_rd    (fx_rd),
		.fx_raddr (fx_raddr),
		.fx_q     (fx_q),
		.bus      (fx_bus0.host),
		.rdata    (ch_rdata)
	);

	// ----------------------------------------
	// channels
	// ----------------------------------------
	for (genvar i = 0; i < `AD_NUM_CH; i++) begin : ch_gen
		ad_cfg_t    cfg;
		logic [7:0] drop_cnt;

		ad_reg #(
			.MOD_ID (`AD_MOD_ID_BASE + 6'(i))
		) reg0 (
			.clk_sys  (clk_sys),
			.rst_n    (rst_n),
			.bus      (fx_bus0.dev),
			.rdata    (ch_rdata[i]),
			.cfg      (cfg),
			.drop_cnt (drop_cnt)
		);

		ad_sample_gen gen0 (
			.clk_sys   (clk_sys),
			.rst_n     (rst_n),
			.cfg       (cfg),
			.adc_data  (adc_data[i]),
			.smp_valid (smp_valid[i]),
			.smp_ready (smp_ready[i]),
			.smp_data  (smp_data[i]),
			.drop_cnt  (drop_cnt)
		);
	end

	// merged output stream
	ad_sample_merge merge0 (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.smp_valid (smp_valid),
		.smp_data  (smp_data),
		.smp_ready (smp_ready),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_data  (out_data),
		.out_ch    (out_ch)
	);

endmodule

// File: source/ad_sample_merge.sv
// round-robin merger of the channel sample streams into one tagged output slice

`include "ad_defines.svh"

module ad_sample_merge (
	input  logic                    clk_sys,
	input  logic                    rst_n,
	input  logic [`AD_NUM_CH-1:0]   smp_valid,
	input  ad_pkg::ad_sample_t      smp_data [`AD_NUM_CH],
	output logic [`AD_NUM_CH-1:0]   smp_ready,
	output logic                    out_valid,
	input  logic                    out_ready,
	output ad_pkg::ad_sample_t      out_data,
	output logic [1:0]              out_ch
);

	logic [1:0] last_ch;
	logic [1:0] grant_idx;
	logic       grant_found;
	logic       slice_free;

	// slice empty or drained on this edge
	assign slice_free = ~out_valid | out_ready;

	// ----------------------------------------
	// arbiter, search starts after last grant
	// ----------------------------------------
	always_comb begin
		int idx;
		grant_found = 1'b0;
		grant_idx   = last_ch;
		for (int k = 1; k <= `AD_NUM_CH; k++) begin
			idx = (int'(last_ch) + k) % `AD_NUM_CH;
			if (!grant_found && smp_valid[idx]) begin
				grant_found = 1'b1;
				grant_idx   = 2'(idx);
			end
		end
	end

	always_comb begin
		for (int i = 0; i < `AD_NUM_CH; i++) begin
			smp_ready[i] = slice_free & grant_found & (grant_idx == 2'(i));
		end
	end

	// ----------------------------------------
	// output slice
	// ----------------------------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			// channel 0 wins first
			last_ch   <= 2'(`AD_NUM_CH - 1);
		end else if (slice_free) begin
			out_valid <= grant_found;
			if (grant_found) begin
				last_ch <= grant_idx;
			end
		end
	end

	// payload and tag
	always_ff @(posedge clk_sys) begin
		if (slice_free && grant_found) begin
			out_data <= smp_data[grant_idx];
			out_ch   <= grant_idx;
		end
	end

endmodule

// File: source/ad_sample_gen.sv
// channel sample generator: rate divider, mode select, test ramp and drop counter

module ad_sample_gen (
	input  logic               clk_sys,
	input  logic               rst_n,
	input  ad_pkg::ad_cfg_t    cfg,
	input  ad_pkg::ad_sample_t adc_data,
	output logic               smp_valid,
	input  logic               smp_ready,
	output ad_pkg::ad_sample_t smp_data,
	output logic [7:0]         drop_cnt
);

	import ad_pkg::*;

	logic [7:0] div_cnt;
	logic       tick;
	logic       xfer;
	logic       slot_free;
	logic       held_ramp;
	ad_sample_t ramp_acc;
	ad_sample_t ramp_next;
	ad_sample_t new_sample;

	assign tick      = (div_cnt == 8'd0);
	assign xfer      = smp_valid & smp_ready;
	// slot is free if empty or handed over on this edge
	assign slot_free = ~smp_valid | smp_ready;
	// wraps modulo 2^24
	assign ramp_next = ramp_acc + ad_sample_t'(cfg.tp_step);

	// ----------------------------------------
	// divider, period max(sample_div,1)
	// ----------------------------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			div_cnt <= 8'd0;
		end else if (tick) begin
			div_cnt <= (cfg.sample_div == 8'd0) ? 8'd0 : cfg.sample_div - 8'd1;
		end else begin
			div_cnt <= div_cnt - 8'd1;
		end
	end

	// ----------------------------------------
	// source select
	// ----------------------------------------
	always_comb begin
		case (cfg.mode)
			AD_MODE_FIX:  new_sample = cfg.fix;
			// take the advanced value if the held ramp sample leaves now
			AD_MODE_RAMP: new_sample = (xfer && held_ramp) ? ramp_next : ramp_acc;
			default:      new_sample = adc_data;
		endcase
	end

	// ----------------------------------------
	// valid, drops, ramp accumulator
	// ----------------------------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			smp_valid <= 1'b0;
			held_ramp <= 1'b0;
			drop_cnt  <= 8'h00;
			ramp_acc  <= '0;
		end else begin
			if (tick && slot_free) begin
				smp_valid <= 1'b1;
				held_ramp <= (cfg.mode == AD_MODE_RAMP);
			end else if (xfer) begin
				smp_valid <= 1'b0;
				held_ramp <= 1'b0;
			end

			// tick lost while the previous sample waits
			if (tick && !slot_free && drop_cnt != 8'hFF) begin
				drop_cnt <= drop_cnt + 8'd1;
			end

			if (cfg.mode != AD_MODE_RAMP || cfg.tp_base_wr) begin
				ramp_acc <= cfg.tp_base;
			end else if (xfer && held_ramp) begin
				ramp_acc <= ramp_next;
			end
		end
	end

	// sample payload
	always_ff @(posedge clk_sys) begin
		if (tick && slot_free) begin
			smp_data <= new_sample;
		end
	end

endmodule

// File: source/ad_reg.sv
// channel register block: fx bus write decode, configuration, debug bytes, read-back

`include "ad_defines.svh"

module ad_reg #(
	parameter logic [5:0] MOD_ID = `AD_MOD_ID_BASE
) (
	input  logic            clk_sys,
	input  logic            rst_n,
	fx_bus_if.dev           bus,
	output logic [7:0]      rdata,
	output ad_pkg::ad_cfg_t cfg,
	input  logic [7:0]      drop_cnt
);

	import ad_pkg::*;

	logic       now_wr;
	logic       now_rd;
	logic       dbg_wsel;
	logic       dbg_rsel;
	logic       base_hit;

	logic [7:0]  cfg_sample;
	logic [7:0]  cfg_tp;
	logic [23:0] cfg_fix;
	logic [23:0] cfg_tp_base;
	logic [7:0]  cfg_tp_step;
	logic [7:0]  dbg [8];
	logic        tp_base_wr;

	// ----------------------------------------
	// address decode
	// ----------------------------------------
	assign now_wr = bus.wr & (bus.waddr[13:8] == MOD_ID);
	assign now_rd = bus.rd & (bus.raddr[13:8] == MOD_ID);

	// debug window 0x80..0x87
	assign dbg_wsel = (bus.waddr[7:3] == `AD_REG_DBG0 >> 3);
	assign dbg_rsel = (bus.raddr[7:3] == `AD_REG_DBG0 >> 3);

	// any of the three tp base bytes
	assign base_hit = (bus.waddr[7:0] >= `AD_REG_BASE0) &&
		(bus.waddr[7:0] <= `AD_REG_BASE0 + 8'd2);

	// ----------------------------------------
	// write registers
	// ----------------------------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cfg_sample  <= 8'd20;
			cfg_tp      <= 8'd0;
			cfg_fix     <= 24'h0;
			cfg_tp_base <= 24'h0;
			cfg_tp_step <= 8'h1;
			for (int i = 0; i < 8; i++) begin
				dbg[i] <= `AD_REG_DBG0 + 8'(i);
			end
		end else if (now_wr) begin
			case (bus.waddr[7:0])
				`AD_REG_SAMPLE:        cfg_sample          <= bus.data;
				`AD_REG_TP:            cfg_tp              <= bus.data;
				`AD_REG_FIX0:          cfg_fix[7:0]        <= bus.data;
				`AD_REG_FIX0 + 8'd1:   cfg_fix[15:8]       <= bus.data;
				`AD_REG_FIX0 + 8'd2:   cfg_fix[23:16]      <= bus.data;
				`AD_REG_BASE0:         cfg_tp_base[7:0]    <= bus.data;
				`AD_REG_BASE0 + 8'd1:  cfg_tp_base[15:8]   <= bus.data;
				`AD_REG_BASE0 + 8'd2:  cfg_tp_base[23:16]  <= bus.data;
				`AD_REG_STEP:          cfg_tp_step         <= bus.data;
				default: begin
					if (dbg_wsel) begin
						dbg[bus.waddr[2:0]] <= bus.data;
					end
				end
			endcase
		end
	end

	// pulse lines up with the new tp base value
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			tp_base_wr <= 1'b0;
		end else begin
			tp_base_wr <= now_wr & base_hit;
		end
	end

	// ----------------------------------------
	// read-back, one registered cycle
	// ----------------------------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			rdata <= 8'h00;
		end else if (now_rd) begin
			case (bus.raddr[7:0])
				`AD_REG_ID:            rdata <= {2'b00, MOD_ID};
				`AD_REG_SAMPLE:        rdata <= cfg_sample;
				`AD_REG_DROP:          rdata <= drop_cnt;
				`AD_REG_TP:            rdata <= cfg_tp;
				`AD_REG_FIX0:          rdata <= cfg_fix[7:0];
				`AD_REG_FIX0 + 8'd1:   rdata <= cfg_fix[15:8];
				`AD_REG_FIX0 + 8'd2:   rdata <= cfg_fix[23:16];
				`AD_REG_BASE0:         rdata <= cfg_tp_base[7:0];
				`AD_REG_BASE0 + 8'd1:  rdata <= cfg_tp_base[15:8];
				`AD_REG_BASE0 + 8'd2:  rdata <= cfg_tp_base[23:16];
				`AD_REG_STEP:          rdata <= cfg_tp_step;
				default:               rdata <= dbg_rsel ? dbg[bus.raddr[2:0]] : 8'h00;
			endcase
		end else begin
			rdata <= 8'h00;
		end
	end

	// ----------------------------------------
	// configuration out
	// ----------------------------------------
	always_comb begin
		cfg.sample_div = cfg_sample;
		cfg.mode       = ad_mode_e'(cfg_tp[1:0]);
		cfg.fix        = cfg_fix;
		cfg.tp_base    = cfg_tp_base;
		cfg.tp_step    = cfg_tp_step;
		cfg.tp_base_wr = tp_base_wr;
	end

endmodule

// File: source/fx_bus_port.sv
// fx bus port: input register, fan-out to the channels and OR of the read returns

`include "ad_defines.svh"

module fx_bus_port (
	input  logic        clk_sys,
	input  logic        rst_n,
	input  logic        fx_wr,
	input  logic [15:0] fx_waddr,
	input  logic [7:0]  fx_data,
	input  logic        fx_rd,
	input  logic [15:0] fx_raddr,
	output logic [7:0]  fx_q,
	fx_bus_if.host      bus,
	input  logic [7:0]  rdata [`AD_NUM_CH]
);

	logic [7:0] rdata_or;

	// ----------------------------------------
	// input register
	// ----------------------------------------

	// strobes
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			bus.wr <= 1'b0;
			bus.rd <= 1'b0;
		end else begin
			bus.wr <= fx_wr;
			bus.rd <= fx_rd;
		end
	end

	// address and data, only qualified by the strobes
	always_ff @(posedge clk_sys) begin
		bus.waddr <= fx_waddr;
		bus.data  <= fx_data;
		bus.raddr <= fx_raddr;
	end

	// ----------------------------------------
	// read return
	// ----------------------------------------

	// unselected channels return zero
	always_comb begin
		rdata_or = 8'h00;
		for (int i = 0; i < `AD_NUM_CH; i++) begin
			rdata_or = rdata_or | rdata[i];
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			fx_q <= 8'h00;
		end else begin
			fx_q <= rdata_or;
		end
	end

endmodule

// File: source/fx_bus_if.sv
// registered fx bus fanned out from the port block to every channel register block

interface fx_bus_if;

	// write strobe, address and data
	logic        wr;
	logic [15:0] waddr;
	logic [7:0]  data;

	// read strobe and address
	logic        rd;
	logic [15:0] raddr;

	// port block side
	modport host (
		output wr, waddr, data, rd, raddr
	);

	// channel side
	modport dev (
		input wr, waddr, data, rd, raddr
	);

endinterface

// File: source/ad_pkg.sv
// acquisition types shared by the channel register block, generator and top level

package ad_pkg;

	// ----------------------------------------
	// sample value
	// ----------------------------------------
	typedef logic [23:0] ad_sample_t;

	// ----------------------------------------
	// channel mode, bits 1:0 of the tp register
	// code 3 is reserved and runs as adc
	// ----------------------------------------
	typedef enum logic [1:0] {
		AD_MODE_ADC  = 2'd0,
		AD_MODE_FIX  = 2'd1,
		AD_MODE_RAMP = 2'd2
	} ad_mode_e;

	// ----------------------------------------
	// per-channel configuration
	// ----------------------------------------
	typedef struct packed {
		// divider in clk_sys cycles, 0 runs as 1
		logic [7:0] sample_div;
		ad_mode_e   mode;
		ad_sample_t fix;
		ad_sample_t tp_base;
		logic [7:0] tp_step;
		// one-cycle pulse on any tp_base byte write
		logic       tp_base_wr;
	} ad_cfg_t;

endpackage

// File: source/ad_defines.svh
// acquisition front end constants: channel count, module ids and register map

`ifndef AD_DEFINES_SVH
`define AD_DEFINES_SVH

// channel count and first module id
`define AD_NUM_CH      4
`define AD_MOD_ID_BASE 6'h10

// ----------------------------------------
// register offsets, address bits 7:0
// ----------------------------------------
`define AD_REG_ID      8'h00
`define AD_REG_SAMPLE  8'h20
`define AD_REG_DROP    8'h21
`define AD_REG_TP      8'h40
// fix occupies 0x41..0x43, low byte first
`define AD_REG_FIX0    8'h41
// tp base occupies 0x44..0x46, low byte first
`define AD_REG_BASE0   8'h44
`define AD_REG_STEP    8'h47
// eight debug bytes at 0x80..0x87
`define AD_REG_DBG0    8'h80

`endif
